/* common/spi_pkg.sv */
package spi_pkg;

    // link timing and frame geometry
    localparam int SCLK_DIV     = 4;
    localparam int FRAME_BITS   = 16;
    localparam int ADDR_BITS    = 7;

    // channel count capture
    localparam int COUNT_BITS   = 10;
    localparam int NUM_CHANNELS = 8;

    // register map
    localparam logic [ADDR_BITS-1:0] REG_TRIG_MASK   = 7'h01;
    localparam logic [ADDR_BITS-1:0] REG_INSTRUCTION = 7'h02;
    localparam logic [ADDR_BITS-1:0] REG_MODE        = 7'h03;
    localparam logic [ADDR_BITS-1:0] REG_SCRATCH     = 7'h04;

    // channel c low byte at CHAN_BASE + 2c, high byte right after it
    localparam logic [ADDR_BITS-1:0] CHAN_BASE       = 7'h10;

    // instruction register bits, self-clearing
    localparam int INST_START_BIT   = 0;
    localparam int INST_CAPTURE_BIT = 1;

    // write view of a command frame
    typedef struct packed {
        logic                 is_write;
        logic [ADDR_BITS-1:0] addr;
        logic [7:0]           data;
    } spi_write_frame_t;

    // read view, low byte is the register count
    typedef struct packed {
        logic                 is_write;
        logic [ADDR_BITS-1:0] addr;
        logic [7:0]           count;
    } spi_read_frame_t;

    // one 16-bit frame word, decoded by its write flag
    typedef union packed {
        spi_write_frame_t wr;
        spi_read_frame_t  rd;
    } spi_frame_u;

endpackage

/* common/spi_if.sv */
`timescale 1ns/1ps

interface spi_if;

    // serial clock, driven low between frames
    logic sclk;
    // frame select, active high
    logic cs;
    logic mosi;
    logic miso;

    modport controller (
        output sclk,
        output cs,
        output mosi,
        input  miso
    );

    modport target (
        input  sclk,
        input  cs,
        input  mosi,
        output miso
    );

endinterface

/* spi_driver/spi_driver.sv */
`timescale 1ns/1ps

module spi_driver (
    input  logic        clk,
    input  logic        rst,
    input  logic        new_command,
    input  logic        is_write,
    input  logic [7:0]  write_addr,
    input  logic [7:0]  write_data,
    input  logic [7:0]  start_read_addr,
    input  logic [7:0]  num_regs_to_read,
    output logic [7:0]  data_read_from_reg,
    output logic        fifo_wr_en,
    output logic        write_complete,
    output logic        read_complete,
    output logic        busy,
    spi_if.controller   link
);

    spi_pkg::spi_frame_u cmd_frame;

    logic [$clog2(spi_pkg::SCLK_DIV)-1:0] div_cnt;
    logic [3:0]  bit_cnt;
    logic [7:0]  bytes_left;
    logic        in_readback;
    logic        op_write;
    logic [15:0] tx_sr;
    logic [7:0]  rx_sr;

    // assemble the command word in whichever view matches the request
    always_comb begin
        cmd_frame = '0;
        if (is_write) begin
            cmd_frame.wr.is_write = 1'b1;
            cmd_frame.wr.addr     = write_addr[spi_pkg::ADDR_BITS-1:0];
            cmd_frame.wr.data     = write_data;
        end else begin
            cmd_frame.rd.is_write = 1'b0;
            cmd_frame.rd.addr     = start_read_addr[spi_pkg::ADDR_BITS-1:0];
            cmd_frame.rd.count    = num_regs_to_read;
        end
    end

    always_ff @(posedge clk) begin
        fifo_wr_en     <= 1'b0;
        write_complete <= 1'b0;
        read_complete  <= 1'b0;
        if (rst) begin
            busy               <= 1'b0;
            link.cs            <= 1'b0;
            link.sclk          <= 1'b0;
            link.mosi          <= 1'b0;
            div_cnt            <= '0;
            bit_cnt            <= '0;
            bytes_left         <= '0;
            in_readback        <= 1'b0;
            op_write           <= 1'b0;
            data_read_from_reg <= '0;
        end else if (!busy) begin
            // commands only taken while idle, others are dropped
            if (new_command) begin
                busy        <= 1'b1;
                link.cs     <= 1'b1;
                link.sclk   <= 1'b0;
                link.mosi   <= cmd_frame[spi_pkg::FRAME_BITS-1];
                tx_sr       <= cmd_frame;
                div_cnt     <= '0;
                bit_cnt     <= '0;
                in_readback <= 1'b0;
                op_write    <= is_write;
                bytes_left  <= (cmd_frame.rd.count == 8'd0) ? 8'd1 : cmd_frame.rd.count;
            end
        end else begin
            div_cnt <= div_cnt + 1'b1;
            if (int'(div_cnt) == spi_pkg::SCLK_DIV / 2 - 1) begin
                // rising edge, sample readback
                link.sclk <= 1'b1;
                if (in_readback) begin
                    rx_sr <= {rx_sr[6:0], link.miso};
                    if (bit_cnt == 4'd7) begin
                        data_read_from_reg <= {rx_sr[6:0], link.miso};
                        fifo_wr_en         <= 1'b1;
                    end
                end
            end else if (int'(div_cnt) == spi_pkg::SCLK_DIV - 1) begin
                // falling edge ends the bit period
                link.sclk <= 1'b0;
                div_cnt   <= '0;
                if (!in_readback) begin
                    if (bit_cnt == 4'(spi_pkg::FRAME_BITS - 1)) begin
                        bit_cnt   <= '0;
                        link.mosi <= 1'b0;
                        if (op_write) begin
                            busy           <= 1'b0;
                            link.cs        <= 1'b0;
                            write_complete <= 1'b1;
                        end else begin
                            in_readback <= 1'b1;
                        end
                    end else begin
                        bit_cnt   <= bit_cnt + 1'b1;
                        tx_sr     <= {tx_sr[14:0], 1'b0};
                        link.mosi <= tx_sr[14];
                    end
                end else if (bit_cnt == 4'd7) begin
                    bit_cnt    <= '0;
                    bytes_left <= bytes_left - 1'b1;
                    if (bytes_left == 8'd1) begin
                        busy          <= 1'b0;
                        link.cs       <= 1'b0;
                        in_readback   <= 1'b0;
                        read_complete <= 1'b1;
                    end
                end else begin
                    bit_cnt <= bit_cnt + 1'b1;
                end
            end
        end
    end

    // bytes are only ever delivered for read commands
    a_no_fifo_on_write: assert property (
        @(posedge clk) disable iff (rst) op_write |-> !fifo_wr_en
    );

endmodule

/* spi_peripheral/spi_peripheral.sv */
`timescale 1ns/1ps

module spi_peripheral (
    input  logic        clk,
    input  logic        rst,
    spi_if.target       link,
    output logic [7:0]  trigger_mask,
    output logic [7:0]  mode,
    output logic        inst_start,
    output logic        capture,
    output logic [3:0]  chan_byte_addr,
    input  logic [7:0]  chan_byte
);

    spi_pkg::spi_frame_u rx_frame;

    logic        sclk_q;
    logic        sclk_rise;
    logic        sclk_fall;
    logic [14:0] frame_sr;
    logic [3:0]  frame_cnt;
    logic        frame_done;
    logic        reading;
    logic [spi_pkg::ADDR_BITS-1:0] rd_addr;
    logic [2:0]  rd_bit;
    logic [7:0]  tx_sr;
    logic [7:0]  scratch;
    logic [7:0]  rd_value;

    // sclk comes from the same clk domain, plain edge detect is enough
    assign sclk_rise = link.sclk & ~sclk_q;
    assign sclk_fall = ~link.sclk & sclk_q;

    // full frame as seen on the 16th rising edge
    assign rx_frame = {frame_sr, link.mosi};

    assign chan_byte_addr = rd_addr[3:0];

    // readback mux, unmapped and instruction addresses read zero
    always_comb begin
        rd_value = '0;
        if (rd_addr[6:4] == spi_pkg::CHAN_BASE[6:4]) begin
            rd_value = chan_byte;
        end else begin
            case (rd_addr)
                spi_pkg::REG_TRIG_MASK: rd_value = trigger_mask;
                spi_pkg::REG_MODE:      rd_value = mode;
                spi_pkg::REG_SCRATCH:   rd_value = scratch;
                default:                rd_value = '0;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            sclk_q       <= 1'b0;
            frame_cnt    <= '0;
            frame_done   <= 1'b0;
            reading      <= 1'b0;
            rd_bit       <= '0;
            link.miso    <= 1'b0;
            trigger_mask <= '0;
            mode         <= '0;
            scratch      <= '0;
            inst_start   <= 1'b0;
            capture      <= 1'b0;
        end else begin
            sclk_q     <= link.sclk;
            inst_start <= 1'b0;
            capture    <= 1'b0;
            if (!link.cs) begin
                frame_cnt  <= '0;
                frame_done <= 1'b0;
                reading    <= 1'b0;
                rd_bit     <= '0;
                link.miso  <= 1'b0;
            end else if (sclk_rise && !frame_done) begin
                frame_sr  <= {frame_sr[13:0], link.mosi};
                frame_cnt <= frame_cnt + 1'b1;
                if (frame_cnt == 4'(spi_pkg::FRAME_BITS - 1)) begin
                    frame_done <= 1'b1;
                    if (rx_frame.wr.is_write) begin
                        case (rx_frame.wr.addr)
                            spi_pkg::REG_TRIG_MASK: trigger_mask <= rx_frame.wr.data;
                            spi_pkg::REG_MODE:      mode         <= rx_frame.wr.data;
                            spi_pkg::REG_SCRATCH:   scratch      <= rx_frame.wr.data;
                            spi_pkg::REG_INSTRUCTION: begin
                                inst_start <= rx_frame.wr.data[spi_pkg::INST_START_BIT];
                                capture    <= rx_frame.wr.data[spi_pkg::INST_CAPTURE_BIT];
                            end
                            default: ;
                        endcase
                    end else begin
                        reading <= 1'b1;
                        rd_addr <= rx_frame.rd.addr;
                    end
                end
            end else if (sclk_fall && reading) begin
                rd_bit <= rd_bit + 1'b1;
                if (rd_bit == 3'd0) begin
                    // byte boundary, fetch and step the address
                    link.miso <= rd_value[7];
                    tx_sr     <= {rd_value[6:0], 1'b0};
                    rd_addr   <= rd_addr + 1'b1;
                end else begin
                    link.miso <= tx_sr[7];
                    tx_sr     <= {tx_sr[6:0], 1'b0};
                end
            end
        end
    end

    a_inst_start_pulse: assert property (
        @(posedge clk) disable iff (rst) inst_start |=> !inst_start
    );

    a_capture_pulse: assert property (
        @(posedge clk) disable iff (rst) capture |=> !capture
    );

endmodule

/* source/channel_bank.sv */
`timescale 1ns/1ps

module channel_bank (
    input  logic clk,
    input  logic rst,
    input  logic [spi_pkg::NUM_CHANNELS-1:0][spi_pkg::COUNT_BITS-1:0] counts_in,
    input  logic capture,
    input  logic [3:0] byte_addr,
    output logic [7:0] rd_byte
);

    logic [spi_pkg::NUM_CHANNELS-1:0][spi_pkg::COUNT_BITS-1:0] held;
    logic [spi_pkg::COUNT_BITS-1:0] sel_count;

    // snapshot of all channels, kept until the next capture
    always_ff @(posedge clk) begin
        if (rst) begin
            held <= '0;
        end else if (capture) begin
            held <= counts_in;
        end
    end

    // upper address bits pick the channel
    assign sel_count = held[byte_addr[3:1]];

    // odd address is the high byte, zero-extended
    always_comb begin
        if (byte_addr[0]) begin
            rd_byte = {{(16 - spi_pkg::COUNT_BITS){1'b0}},
                       sel_count[spi_pkg::COUNT_BITS-1:8]};
        end else begin
            rd_byte = sel_count[7:0];
        end
    end

    a_high_byte_zero: assert property (
        @(posedge clk) disable iff (rst)
            byte_addr[0] |-> rd_byte[7:spi_pkg::COUNT_BITS-8] == '0
    );

endmodule

/* source/slow_control_top.sv */
`timescale 1ns/1ps

module slow_control_top (
    input  logic        clk,
    input  logic        rst,
    input  logic        new_command,
    input  logic        is_write,
    input  logic [7:0]  write_addr,
    input  logic [7:0]  write_data,
    input  logic [7:0]  start_read_addr,
    input  logic [7:0]  num_regs_to_read,
    input  logic [spi_pkg::NUM_CHANNELS-1:0][spi_pkg::COUNT_BITS-1:0] counts_in,
    output logic [7:0]  data_read_from_reg,
    output logic        fifo_wr_en,
    output logic        write_complete,
    output logic        read_complete,
    output logic        busy,
    output logic [7:0]  trigger_mask,
    output logic [7:0]  mode,
    output logic        inst_start
);

    logic       capture;
    logic [3:0] chan_byte_addr;
    logic [7:0] chan_byte;

    // serial link between FPGA driver and chip peripheral
    spi_if link ();

    spi_driver u_driver (
        .clk                (clk),
        .rst                (rst),
        .new_command        (new_command),
        .is_write           (is_write),
        .write_addr         (write_addr),
        .write_data         (write_data),
        .start_read_addr    (start_read_addr),
        .num_regs_to_read   (num_regs_to_read),
        .data_read_from_reg (data_read_from_reg),
        .fifo_wr_en         (fifo_wr_en),
        .write_complete     (write_complete),
        .read_complete      (read_complete),
        .busy               (busy),
        .link               (link.controller)
    );

    spi_peripheral u_peripheral (
        .clk            (clk),
        .rst            (rst),
        .link           (link.target),
        .trigger_mask   (trigger_mask),
        .mode           (mode),
        .inst_start     (inst_start),
        .capture        (capture),
        .chan_byte_addr (chan_byte_addr),
        .chan_byte      (chan_byte)
    );

    channel_bank u_channels (
        .clk       (clk),
        .rst       (rst),
        .counts_in (counts_in),
        .capture   (capture),
        .byte_addr (chan_byte_addr),
        .rd_byte   (chan_byte)
    );

endmodule

/* testbench/slow_control_tb.sv */
`timescale 1ns/1ps

module slow_control_tb;

    typedef enum logic [1:0] {OP_WRITE, OP_READ, OP_COUNTS, OP_BUSY} op_e;

    // rnd set means the data byte is drawn at run time
    typedef struct packed {
        op_e        op;
        logic [7:0] addr;
        logic [7:0] data;
        logic       rnd;
    } test_t;

    localparam int NUM_TESTS      = 16;
    localparam int TIMEOUT_CYCLES = NUM_TESTS * 200;

    localparam test_t TESTS [NUM_TESTS] = '{
        '{OP_READ,   {1'b0, spi_pkg::REG_TRIG_MASK},   8'd4,  1'b0},
        '{OP_WRITE,  {1'b0, spi_pkg::REG_TRIG_MASK},   8'h00, 1'b1},
        '{OP_WRITE,  {1'b0, spi_pkg::REG_MODE},        8'h00, 1'b1},
        '{OP_WRITE,  {1'b0, spi_pkg::REG_SCRATCH},     8'h00, 1'b1},
        '{OP_READ,   {1'b0, spi_pkg::REG_TRIG_MASK},   8'd4,  1'b0},
        '{OP_WRITE,  {1'b0, spi_pkg::REG_INSTRUCTION}, 8'h01, 1'b0},
        '{OP_READ,   {1'b0, spi_pkg::REG_INSTRUCTION}, 8'd1,  1'b0},
        '{OP_COUNTS, 8'h00,                            8'h00, 1'b0},
        '{OP_WRITE,  {1'b0, spi_pkg::REG_INSTRUCTION}, 8'h02, 1'b0},
        '{OP_READ,   {1'b0, spi_pkg::CHAN_BASE},       8'd16, 1'b0},
        '{OP_COUNTS, 8'h00,                            8'h00, 1'b0},
        '{OP_READ,   {1'b0, spi_pkg::CHAN_BASE},       8'd16, 1'b0},
        '{OP_READ,   8'h30,                            8'd3,  1'b0},
        '{OP_READ,   8'h05,                            8'd0,  1'b0},
        '{OP_BUSY,   {1'b0, spi_pkg::REG_TRIG_MASK},   8'h00, 1'b1},
        '{OP_READ,   {1'b0, spi_pkg::REG_TRIG_MASK},   8'd4,  1'b0}
    };

    logic       clk = 1'b0;
    logic       rst;
    logic       new_command;
    logic       is_write;
    logic [7:0] write_addr;
    logic [7:0] write_data;
    logic [7:0] start_read_addr;
    logic [7:0] num_regs_to_read;
    logic [spi_pkg::NUM_CHANNELS-1:0][spi_pkg::COUNT_BITS-1:0] counts_in;
    logic [7:0] data_read_from_reg;
    logic       fifo_wr_en;
    logic       write_complete;
    logic       read_complete;
    logic       busy;
    logic [7:0] trigger_mask;
    logic [7:0] mode;
    logic       inst_start;

    // reference model of the register map and the captured counts
    logic [7:0] reg_model [0:127];
    logic [spi_pkg::NUM_CHANNELS-1:0][spi_pkg::COUNT_BITS-1:0] cap_model;

    logic [7:0] rx_bytes [$];
    int inst_pulses = 0;
    int cycles      = 0;
    int checks      = 0;
    int errors      = 0;

    slow_control_top DUT (.*);

    always #5 clk = ~clk;

    always @(posedge clk) begin
        if (fifo_wr_en) begin
            rx_bytes.push_back(data_read_from_reg);
        end
        if (inst_start) begin
            inst_pulses++;
        end
    end

    always @(posedge clk) begin
        cycles++;
        if (cycles == TIMEOUT_CYCLES) begin
            $display("timeout: the tests did not finish within %0d cycles", TIMEOUT_CYCLES);
            $display("CHECKS FAILED");
            $finish;
        end
    end

    // channel range first, everything else from the register model
    function automatic logic [7:0] expected_byte(input logic [6:0] a);
        logic [spi_pkg::COUNT_BITS-1:0] cnt;
        cnt = cap_model[a[3:1]];
        if (a[6:4] == 3'b001) begin
            return a[0] ? {6'b0, cnt[9:8]} : cnt[7:0];
        end
        return reg_model[a];
    endfunction

    task automatic check_byte(input int idx, input logic [7:0] got, input logic [7:0] exp);
        checks++;
        if (got !== exp) begin
            errors++;
            $display("FAILED at %0t: byte %0d read 0x%02h, expected 0x%02h",
                     $time, idx, got, exp);
        end
    endtask

    task automatic check_reg(input string name, input logic [7:0] got, input logic [7:0] exp);
        checks++;
        if (got !== exp) begin
            errors++;
            $display("FAILED at %0t: %s is 0x%02h, expected 0x%02h", $time, name, got, exp);
        end
    endtask

    task automatic check_flag(input string name, input logic got, input logic exp);
        checks++;
        if (got !== exp) begin
            errors++;
            $display("FAILED at %0t: %s is %0b, expected %0b", $time, name, got, exp);
        end
    endtask

    task automatic check_pulses(input string name, input int got, input int exp);
        checks++;
        if (got != exp) begin
            errors++;
            $display("FAILED at %0t: %s pulsed %0d times, expected %0d", $time, name, got, exp);
        end
    endtask

    task automatic send_command(input logic wr, input logic [7:0] addr, input logic [7:0] data);
        @(posedge clk);
        new_command      <= 1'b1;
        is_write         <= wr;
        write_addr       <= addr;
        write_data       <= data;
        start_read_addr  <= addr;
        num_regs_to_read <= data;
        @(posedge clk);
        new_command <= 1'b0;
        // busy follows one cycle after the command is taken
        @(posedge clk);
        check_flag("busy", busy, 1'b1);
    endtask

    task automatic wait_done(input logic wr);
        do begin
            @(posedge clk);
        end while (!(write_complete || read_complete));
        // busy falls together with the completion strobe
        check_flag("write_complete", write_complete, wr);
        check_flag("read_complete", read_complete, !wr);
        check_flag("busy", busy, 1'b0);
    endtask

    task automatic load_counts();
        logic [spi_pkg::COUNT_BITS-1:0] value;
        @(posedge clk);
        for (int c = 0; c < spi_pkg::NUM_CHANNELS; c++) begin
            value = $urandom;
            counts_in[c] <= value;
        end
    endtask

    initial begin
        logic [7:0] data;
        logic [7:0] addr;
        int exp_n;
        int err_before;
        void'($urandom(32'h4a5f_6adb));
        rst              = 1'b1;
        new_command      = 1'b0;
        is_write         = 1'b0;
        write_addr       = '0;
        write_data       = '0;
        start_read_addr  = '0;
        num_regs_to_read = '0;
        counts_in        = '0;
        cap_model        = '0;
        foreach (reg_model[a]) begin
            reg_model[a] = '0;
        end
        repeat (3) @(posedge clk);
        rst <= 1'b0;

        for (int i = 0; i < NUM_TESTS; i++) begin
            err_before = errors;
            addr = TESTS[i].addr;
            data = TESTS[i].rnd ? 8'($urandom) : TESTS[i].data;
            inst_pulses = 0;
            rx_bytes.delete();
            case (TESTS[i].op)
                OP_WRITE, OP_BUSY: begin
                    send_command(1'b1, addr, data);
                    if (TESTS[i].op == OP_BUSY) begin
                        // second command lands while the first is still on the link
                        repeat (4) @(posedge clk);
                        new_command <= 1'b1;
                        write_addr  <= {1'b0, spi_pkg::REG_MODE};
                        write_data  <= ~reg_model[spi_pkg::REG_MODE];
                        @(posedge clk);
                        new_command <= 1'b0;
                    end
                    wait_done(1'b1);
                    check_pulses("fifo_wr_en", rx_bytes.size(), 0);
                    if (addr == 8'(spi_pkg::REG_INSTRUCTION)) begin
                        if (data[spi_pkg::INST_CAPTURE_BIT]) begin
                            cap_model = counts_in;
                        end
                    end else if (addr inside {8'h01, 8'h03, 8'h04}) begin
                        reg_model[addr[6:0]] = data;
                    end
                end
                OP_READ: begin
                    send_command(1'b0, addr, data);
                    wait_done(1'b0);
                    exp_n = (data == 8'd0) ? 1 : int'(data);
                    check_pulses("fifo_wr_en", rx_bytes.size(), exp_n);
                    for (int k = 0; k < exp_n && k < rx_bytes.size(); k++) begin
                        check_byte(k, rx_bytes[k], expected_byte(7'(addr + k)));
                    end
                end
                default: load_counts();
            endcase
            exp_n = (TESTS[i].op == OP_WRITE && addr == 8'(spi_pkg::REG_INSTRUCTION)) ?
                    int'(data[spi_pkg::INST_START_BIT]) : 0;
            check_pulses("inst_start", inst_pulses, exp_n);
            check_reg("trigger_mask", trigger_mask, reg_model[spi_pkg::REG_TRIG_MASK]);
            check_reg("mode", mode, reg_model[spi_pkg::REG_MODE]);
            $display("test %0d %s addr 0x%02h data 0x%02h: %s", i, TESTS[i].op.name(),
                     addr, data, (errors == err_before) ? "ok" : "mismatch");
        end

        $display("%0d tests, %0d checks, %0d errors", NUM_TESTS, checks, errors);
        if (errors == 0) begin
            $display("ALL CHECKS PASSED");
        end else begin
            $display("CHECKS FAILED");
        end
        $finish;
    end

endmodule

/* project.f */
common/spi_pkg.sv
common/spi_if.sv
spi_driver/spi_driver.sv
spi_peripheral/spi_peripheral.sv
source/channel_bank.sv
source/slow_control_top.sv
testbench/slow_control_tb.sv

/* run_sim.sh */
#!/bin/sh
# build and run the slow-control testbench, fail if the log reports a failure
cd "$(dirname "$0")" || exit 1
verilator --binary --timing --assert -Wno-fatal --top-module slow_control_tb \
    -f project.f -o slow_control_sim > build.log 2>&1 \
    && ./obj_dir/slow_control_sim > sim.log 2>&1 \
    && ! grep -q "CHECKS FAILED" sim.log \
    && echo "simulation passed" \
    || { echo "simulation failed, see build.log and sim.log"; exit 1; }
